// File: common/zx_ports_cfg.svh
/*
 * zx ports configuration
 * port addresses, #AF extension indexes and register reset values
 */
`ifndef ZX_PORTS_CFG_SVH
`define ZX_PORTS_CFG_SVH

////////////////////////////////////////////////////////////
// port addresses, low byte of the z80 i/o address
`define ZXP_PORTFE        8'hFE
`define ZXP_PORTF6        8'hF6
`define ZXP_PORTFD        8'hFD  // 7ffd paging, AY when a15 is set
`define ZXP_PORTF7        8'hF7  // eff7
`define ZXP_PORTXT        8'hAF  // extension port #nnAF
`define ZXP_PORTBE        8'hBE  // config readback

////////////////////////////////////////////////////////////
// #nnAF indexes, high byte of the address
`define ZXP_XT_STATUS     8'h00  // read side only
`define ZXP_XT_RAMPAGE    8'h10  // #10..#13
`define ZXP_XT_FMADDR     8'h15
`define ZXP_XT_SYSCONF    8'h20
`define ZXP_XT_MEMCONF    8'h21
`define ZXP_XT_IM2VECT    8'h25
`define ZXP_XT_FDDVIRT    8'h29
`define ZXP_XT_OVERRIDE   8'h2A

// video block indexes, forwarded and not kept here
`define ZXP_XT_VID_LAST   8'h07  // #00..#07
`define ZXP_XT_XBORDER    8'h0F
`define ZXP_XT_TGPAGE     8'h18
`define ZXP_XT_HSINT      8'h22
`define ZXP_XT_VSINTH     8'h24  // #22..#24 are interrupt positions

////////////////////////////////////////////////////////////
`define ZXP_RST_SYSCONF   8'h01  // 7 MHz turbo
`define ZXP_RST_MEMCONF   8'h00
`define ZXP_RST_IM2VECT   8'hFF
`define ZXP_RST_RAMPAGE0  8'h00
`define ZXP_RST_RAMPAGE1  8'h05
`define ZXP_RST_RAMPAGE2  8'h02
`define ZXP_RST_RAMPAGE3  8'h00

`define ZXP_EFF7_MASK     8'b10110001  // applied when eff7 bit 2 blocks 1M

`endif

// File: common/zx_ports_pkg.sv
/*
 * zx ports shared types
 * bus, strobe, command, video and register bank structures
 */
package zx_ports_pkg;

	typedef logic [15:0] addr_t;  // z80 i/o address
	typedef logic [7:0]  data_t;
	typedef logic [7:0]  page_t;  // ram page number

	// raw z80 bus, 27 bits
	typedef struct packed {
		logic  iorq_n;
		logic  rd_n;
		logic  wr_n;
		addr_t addr;
		data_t din;
	} z80_bus_t;

	// one-cycle strobes with the latched address and data, 26 bits
	typedef struct packed {
		logic  wr;
		logic  rd;
		addr_t addr;
		data_t data;
	} io_cycle_t;

	// decoded write target
	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_XT,
		CMD_7FFD,
		CMD_EFF7,
		CMD_VIDEO
	} port_cmd_e;

	typedef struct packed {
		port_cmd_e kind;
		data_t     idx;   // high address byte
		data_t     data;
	} port_cmd_t;

	typedef struct packed {
		logic  valid;
		data_t reg_idx;
		data_t data;
	} video_wr_t;

	// register bank state, 85 bits
	typedef struct packed {
		page_t [3:0] rampage;
		logic  [3:0] xt_override;
		logic  [4:0] fmaddr;
		data_t       sysconf;
		data_t       memconf;
		data_t       im2vect;
		logic  [3:0] fddvirt;
		data_t       p7ffd;
		data_t       peff7;
	} cfg_regs_t;

endpackage

// File: verilog/io_strobe_sync.sv
/*
 * z80 i/o strobe generator
 * one-cycle write and read strobes on the leading edge of an i/o cycle
 */
`timescale 1ns/1ns

module io_strobe_sync (
	input  logic                   zclk,
	input  logic                   rst_n,
	input  zx_ports_pkg::z80_bus_t bus,
	output zx_ports_pkg::io_cycle_t cycle
);

	logic iowr;
	logic iord;
	logic iowr_q;  // qualifiers seen on the previous edge
	logic iord_q;
	logic wr_q;
	logic rd_q;
	logic wr_edge;
	logic rd_edge;
	zx_ports_pkg::addr_t addr_q;
	zx_ports_pkg::data_t data_q;

	assign iowr = ~(bus.iorq_n | bus.wr_n);
	assign iord = ~(bus.iorq_n | bus.rd_n);

	assign wr_edge = iowr & ~iowr_q;
	assign rd_edge = iord & ~iord_q;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_q <= 1'b0;
			iord_q <= 1'b0;
			wr_q   <= 1'b0;
			rd_q   <= 1'b0;
		end
		else
		begin
			iowr_q <= iowr;
			iord_q <= iord;
			wr_q   <= wr_edge;  // high for one zclk
			rd_q   <= rd_edge;
		end
	end

	// address and data ride along with the strobe
	always_ff @(posedge zclk)
	begin
		if (wr_edge || rd_edge)
		begin
			addr_q <= bus.addr;
			data_q <= bus.din;
		end
	end

	assign cycle = '{wr: wr_q, rd: rd_q, addr: addr_q, data: data_q};

endmodule

// File: verilog/port_decoder.sv
/*
 * port write decoder
 * turns a write strobe into a registered command and a video register write
 */
`timescale 1ns/1ns
`include "zx_ports_cfg.svh"

module port_decoder (
	input  logic                    zclk,
	input  logic                    rst_n,
	input  zx_ports_pkg::io_cycle_t cycle,
	input  logic                    block7ffd,
	output zx_ports_pkg::port_cmd_t cmd,
	output zx_ports_pkg::video_wr_t video_wr
);

	zx_ports_pkg::data_t     loa;
	zx_ports_pkg::data_t     hoa;
	logic                    is_video;
	zx_ports_pkg::port_cmd_e kind_d;
	zx_ports_pkg::port_cmd_e kind_q;
	zx_ports_pkg::data_t     idx_q;
	zx_ports_pkg::data_t     data_q;

	assign loa = cycle.addr[7:0];
	assign hoa = cycle.addr[15:8];

	// indexes owned by the video block
	assign is_video = (hoa <= `ZXP_XT_VID_LAST) ||
		(hoa == `ZXP_XT_XBORDER) ||
		(hoa == `ZXP_XT_TGPAGE) ||
		((hoa >= `ZXP_XT_HSINT) && (hoa <= `ZXP_XT_VSINTH));

	always_comb
	begin
		kind_d = zx_ports_pkg::CMD_NONE;
		if (cycle.wr)
		begin
			case (loa)
				`ZXP_PORTFD:
					if (!cycle.addr[15] && !block7ffd)  // a15 high is the AY
						kind_d = zx_ports_pkg::CMD_7FFD;
				`ZXP_PORTF7:
					if (cycle.addr[8] && !cycle.addr[12])
						kind_d = zx_ports_pkg::CMD_EFF7;
				`ZXP_PORTXT:
					kind_d = is_video ? zx_ports_pkg::CMD_VIDEO : zx_ports_pkg::CMD_XT;
				default:
					kind_d = zx_ports_pkg::CMD_NONE;
			endcase
		end
	end

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			kind_q <= zx_ports_pkg::CMD_NONE;
		else
			kind_q <= kind_d;
	end

	// payload shared by the bank command and the video write
	always_ff @(posedge zclk)
	begin
		if (cycle.wr)
		begin
			idx_q  <= hoa;
			data_q <= cycle.data;
		end
	end

	assign cmd = '{kind: kind_q, idx: idx_q, data: data_q};

	assign video_wr = '{
		valid:   (kind_q == zx_ports_pkg::CMD_VIDEO),
		reg_idx: idx_q,
		data:    data_q
	};

endmodule

// File: xt_regs/xt_reg_bank.sv
/*
 * paging and configuration register bank
 * #nnAF extension registers, 7ffd paging and eff7
 */
`timescale 1ns/1ns
`include "zx_ports_cfg.svh"

module xt_reg_bank (
	input  logic                    zclk,
	input  logic                    rst_n,
	input  zx_ports_pkg::port_cmd_t cmd,
	output zx_ports_pkg::cfg_regs_t regs
);

	zx_ports_pkg::cfg_regs_t regs_q;
	logic                    lock128;
	logic [1:0]              page_hi;  // 7ffd bits 7..6 as page bits 4..3
	zx_ports_pkg::page_t     page_7ffd;
	logic                    xt_page_hit;

	// memconf mode 01 locks paging to 128K
	assign lock128 = (regs_q.memconf[7:6] == 2'b01);

	assign page_hi   = lock128 ? 2'b00 : cmd.data[7:6];
	assign page_7ffd = {3'b000, page_hi, cmd.data[2:0]};

	assign xt_page_hit = ((cmd.idx & 8'hFC) == `ZXP_XT_RAMPAGE);  // #10..#13

	////////////////////////////////////////////////////////////
	// register writes
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			regs_q.rampage[0]  <= `ZXP_RST_RAMPAGE0;
			regs_q.rampage[1]  <= `ZXP_RST_RAMPAGE1;
			regs_q.rampage[2]  <= `ZXP_RST_RAMPAGE2;
			regs_q.rampage[3]  <= `ZXP_RST_RAMPAGE3;
			regs_q.xt_override <= 4'b0000;
			regs_q.fmaddr      <= 5'd0;
			regs_q.sysconf     <= `ZXP_RST_SYSCONF;
			regs_q.memconf     <= `ZXP_RST_MEMCONF;
			regs_q.im2vect     <= `ZXP_RST_IM2VECT;
			regs_q.fddvirt     <= 4'b0000;
			regs_q.p7ffd       <= 8'h00;
			regs_q.peff7       <= 8'h00;
		end
		else
		begin
			case (cmd.kind)
				zx_ports_pkg::CMD_7FFD:
				begin
					regs_q.p7ffd      <= cmd.data;
					regs_q.memconf[0] <= cmd.data[4];  // rom select
					regs_q.rampage[3] <= page_7ffd;
				end

				zx_ports_pkg::CMD_XT:
				begin
					if (xt_page_hit)
					begin
						regs_q.rampage[cmd.idx[1:0]]     <= cmd.data;
						regs_q.xt_override[cmd.idx[1:0]] <= 1'b1;  // page now set by XT
					end

					case (cmd.idx)
						`ZXP_XT_OVERRIDE:
							regs_q.xt_override <= cmd.data[3:0];
						`ZXP_XT_FMADDR:
							regs_q.fmaddr <= cmd.data[4:0];
						`ZXP_XT_SYSCONF:
							regs_q.sysconf <= cmd.data;
						`ZXP_XT_MEMCONF:
							regs_q.memconf <= cmd.data;
						`ZXP_XT_IM2VECT:
							regs_q.im2vect <= cmd.data;
						`ZXP_XT_FDDVIRT:
							regs_q.fddvirt <= cmd.data[3:0];
						default:
							regs_q.fmaddr <= regs_q.fmaddr;  // pages or unused index
					endcase
				end

				zx_ports_pkg::CMD_EFF7:
					regs_q.peff7 <= cmd.data;  // kept unmasked, masking is on the output

				default:
					regs_q <= regs_q;  // none or video
			endcase
		end
	end

	assign regs = regs_q;

endmodule

// File: verilog/port_read_mux.sv
/*
 * port read mux
 * z80 read data, data-out enable and register derived outputs
 */
`timescale 1ns/1ns
`include "zx_ports_cfg.svh"

module port_read_mux (
	input  zx_ports_pkg::z80_bus_t  bus,
	input  zx_ports_pkg::cfg_regs_t regs,
	input  logic [4:0]              keys_in,
	input  logic                    tape_read,
	input  logic                    dma_act,
	output zx_ports_pkg::data_t     dout,
	output logic                    dataout,
	output logic                    block7ffd,
	output zx_ports_pkg::data_t     peff7
);

	zx_ports_pkg::data_t loa;
	zx_ports_pkg::data_t hoa;
	zx_ports_pkg::data_t xt_rd;
	zx_ports_pkg::data_t be_rd;
	logic                port_hit;
	logic                ay_port;

	assign loa = bus.addr[7:0];
	assign hoa = bus.addr[15:8];

	////////////////////////////////////////////////////////////
	// #nnAF readback
	always_comb
	begin
		case (hoa)
			`ZXP_XT_STATUS:
				xt_rd = {dma_act, 7'b0000000};
			`ZXP_XT_RAMPAGE + 8'd2, `ZXP_XT_RAMPAGE + 8'd3:
				xt_rd = regs.rampage[hoa[1:0]];
			default:
				xt_rd = 8'hFF;
		endcase
	end

	// #xxBE config readback, selected by a11..8
	always_comb
	begin
		case (bus.addr[11:8])
			4'hA:    be_rd = regs.p7ffd;
			4'hB:    be_rd = regs.peff7;  // raw value
			default: be_rd = 8'hFF;
		endcase
	end

	always_comb
	begin
		case (loa)
			`ZXP_PORTFE, `ZXP_PORTF6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			`ZXP_PORTXT:
				dout = xt_rd;
			`ZXP_PORTBE:
				dout = be_rd;
			default:
				dout = 8'hFF;
		endcase
	end

	assign port_hit = (loa == `ZXP_PORTFE) || (loa == `ZXP_PORTF6) ||
		(loa == `ZXP_PORTFD) || (loa == `ZXP_PORTF7) ||
		(loa == `ZXP_PORTXT) || (loa == `ZXP_PORTBE);

	assign ay_port = (loa == `ZXP_PORTFD) && bus.addr[15];  // answered outside

	assign dataout = port_hit && !bus.iorq_n && !bus.rd_n && !ay_port;

	assign block7ffd = regs.p7ffd[5];

	// bit 2 blocks the 1M extension bits
	assign peff7 = regs.peff7[2] ? (regs.peff7 & `ZXP_EFF7_MASK) : regs.peff7;

endmodule

// File: verilog/zx_ports_top.sv
/*
 * zx ports top
 * strobe, decode, register bank and read mux of the paging ports
 */
`timescale 1ns/1ns

module zx_ports_top (
	input  logic                    zclk,
	input  logic                    rst_n,
	input  zx_ports_pkg::z80_bus_t  bus,
	input  logic [4:0]              keys_in,
	input  logic                    tape_read,
	input  logic                    dma_act,
	output zx_ports_pkg::data_t     dout,
	output logic                    dataout,
	output zx_ports_pkg::video_wr_t video_wr,
	output zx_ports_pkg::cfg_regs_t cfg,
	output logic [31:0]             xt_page,
	output zx_ports_pkg::data_t     peff7,
	output logic                    p7ffd_rom,
	output logic                    romrw_en
);

	zx_ports_pkg::io_cycle_t cycle;
	zx_ports_pkg::port_cmd_t cmd;
	logic                    block7ffd;

	io_strobe_sync io_strobe_sync_i (
		.zclk  (zclk),
		.rst_n (rst_n),
		.bus   (bus),
		.cycle (cycle)
	);

	port_decoder port_decoder_i (
		.zclk      (zclk),
		.rst_n     (rst_n),
		.cycle     (cycle),
		.block7ffd (block7ffd),
		.cmd       (cmd),
		.video_wr  (video_wr)
	);

	xt_reg_bank xt_reg_bank_i (
		.zclk  (zclk),
		.rst_n (rst_n),
		.cmd   (cmd),
		.regs  (cfg)
	);

	port_read_mux port_read_mux_i (
		.bus       (bus),
		.regs      (cfg),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.dma_act   (dma_act),
		.dout      (dout),
		.dataout   (dataout),
		.block7ffd (block7ffd),
		.peff7     (peff7)
	);

	assign xt_page   = cfg.rampage;     // page 3 in the top byte
	assign p7ffd_rom = cfg.memconf[0];
	assign romrw_en  = cfg.memconf[1];

endmodule

// File: verif/zx_ports_asserts.sv
/*
 * zx ports bound checks
 * strobe width, video write origin and register reset values
 */
`timescale 1ns/1ns
`include "zx_ports_cfg.svh"

module zx_ports_asserts (
	input logic                    zclk,
	input logic                    rst_n,
	input zx_ports_pkg::io_cycle_t cycle,
	input zx_ports_pkg::video_wr_t video_wr,
	input zx_ports_pkg::cfg_regs_t cfg
);

	bit   wr_long      = 1'b0;  // one flag per property
	bit   rd_long      = 1'b0;
	bit   video_orphan = 1'b0;
	bit   reset_bad    = 1'b0;
	logic any_failed;

	assign any_failed = wr_long | rd_long | video_orphan | reset_bad;

	wr_one_cycle: assert property (@(posedge zclk) disable iff (!rst_n) cycle.wr |=> !cycle.wr)
	else
	begin
		wr_long = 1'b1;
		$error("write strobe longer than one cycle");
	end

	rd_one_cycle: assert property (@(posedge zclk) disable iff (!rst_n) cycle.rd |=> !cycle.rd)
	else
	begin
		rd_long = 1'b1;
		$error("read strobe longer than one cycle");
	end

	// decoder adds one register stage after the strobe
	video_after_wr: assert property (@(posedge zclk) disable iff (!rst_n)
		video_wr.valid |-> $past(cycle.wr))
	else
	begin
		video_orphan = 1'b1;
		$error("video write without a preceding write strobe");
	end

	reset_values: assert property (@(posedge zclk) $rose(rst_n) |->
		(cfg.rampage == {`ZXP_RST_RAMPAGE3, `ZXP_RST_RAMPAGE2, `ZXP_RST_RAMPAGE1,
			`ZXP_RST_RAMPAGE0}) && (cfg.xt_override == 4'h0) && (cfg.fmaddr == 5'd0) &&
		(cfg.sysconf == `ZXP_RST_SYSCONF) && (cfg.memconf == `ZXP_RST_MEMCONF) &&
		(cfg.im2vect == `ZXP_RST_IM2VECT) && (cfg.fddvirt == 4'h0) &&
		(cfg.p7ffd == 8'h00) && (cfg.peff7 == 8'h00))
	else
	begin
		reset_bad = 1'b1;
		$error("register bank not at reset values after reset");
	end

endmodule

// File: verif/tb_zx_ports.sv
/*
 * zx ports testbench
 * z80 bus cycles against a reference model of the paging and config ports
 */
`timescale 1ns/1ns
`include "zx_ports_cfg.svh"

module tb_zx_ports;

	// about 50 bus cycles of 6 clocks each, plus reset, with wide margin
	localparam int MAX_CYCLES = 2000;
	localparam zx_ports_pkg::z80_bus_t BUS_IDLE =
		'{iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1, addr: 16'hFFFF, din: 8'hFF};

	logic                    zclk;
	logic                    rst_n;
	zx_ports_pkg::z80_bus_t  bus;
	logic [4:0]              keys_in;
	logic                    tape_read;
	logic                    dma_act;
	zx_ports_pkg::data_t     dout;
	logic                    dataout;
	zx_ports_pkg::video_wr_t video_wr;
	zx_ports_pkg::cfg_regs_t cfg;
	logic [31:0]             xt_page;
	zx_ports_pkg::data_t     peff7;
	logic                    p7ffd_rom;
	logic                    romrw_en;

	zx_ports_pkg::cfg_regs_t exp_cfg;      // model state
	zx_ports_pkg::video_wr_t video_q[$];   // video writes still expected
	string                   test_name;
	int                      seed = 9299;
	int                      cycle_cnt = 0;

	zx_ports_top zx_ports_top_i (
		.zclk      (zclk),
		.rst_n     (rst_n),
		.bus       (bus),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.dma_act   (dma_act),
		.dout      (dout),
		.dataout   (dataout),
		.video_wr  (video_wr),
		.cfg       (cfg),
		.xt_page   (xt_page),
		.peff7     (peff7),
		.p7ffd_rom (p7ffd_rom),
		.romrw_en  (romrw_en)
	);

	bind zx_ports_top zx_ports_asserts zx_ports_asserts_i (
		.zclk     (zclk),
		.rst_n    (rst_n),
		.cycle    (cycle),
		.video_wr (video_wr),
		.cfg      (cfg)
	);

	initial
	begin
		zclk = 1'b0;
		forever #10 zclk = ~zclk;
	end

	////////////////////////////////////////////////////////////
	// reference model
	function automatic bit is_video_index(zx_ports_pkg::data_t idx);
		return (idx <= `ZXP_XT_VID_LAST) || (idx == `ZXP_XT_XBORDER) ||
			(idx == `ZXP_XT_TGPAGE) || ((idx >= `ZXP_XT_HSINT) && (idx <= `ZXP_XT_VSINTH));
	endfunction

	function automatic zx_ports_pkg::cfg_regs_t reset_cfg();
		zx_ports_pkg::cfg_regs_t r;
		r.rampage     = {`ZXP_RST_RAMPAGE3, `ZXP_RST_RAMPAGE2, `ZXP_RST_RAMPAGE1,
			`ZXP_RST_RAMPAGE0};
		r.xt_override = 4'h0;
		r.fmaddr      = 5'd0;
		r.sysconf     = `ZXP_RST_SYSCONF;
		r.memconf     = `ZXP_RST_MEMCONF;
		r.im2vect     = `ZXP_RST_IM2VECT;
		r.fddvirt     = 4'h0;
		r.p7ffd       = 8'h00;
		r.peff7       = 8'h00;
		return r;
	endfunction

	function automatic zx_ports_pkg::cfg_regs_t model_write(zx_ports_pkg::cfg_regs_t cur,
		zx_ports_pkg::addr_t addr, zx_ports_pkg::data_t data);
		zx_ports_pkg::cfg_regs_t nxt;
		zx_ports_pkg::data_t     idx;
		logic [1:0]              hi_bits;
		nxt = cur;
		idx = addr[15:8];
		if ((addr[7:0] == `ZXP_PORTFD) && !addr[15] && !cur.p7ffd[5])
		begin
			hi_bits = (cur.memconf[7:6] == 2'b01) ? 2'b00 : data[7:6];  // lock128
			nxt.p7ffd      = data;
			nxt.memconf[0] = data[4];
			nxt.rampage[3] = {3'b000, hi_bits, data[2:0]};
		end
		else if ((addr[7:0] == `ZXP_PORTF7) && addr[8] && !addr[12])
			nxt.peff7 = data;
		else if ((addr[7:0] == `ZXP_PORTXT) && !is_video_index(idx))
		begin
			if ((idx >= 8'h10) && (idx <= 8'h13))
			begin
				nxt.rampage[idx[1:0]]     = data;
				nxt.xt_override[idx[1:0]] = 1'b1;
			end
			else if (idx == `ZXP_XT_OVERRIDE)
				nxt.xt_override = data[3:0];
			else if (idx == `ZXP_XT_FMADDR)
				nxt.fmaddr = data[4:0];
			else if (idx == `ZXP_XT_SYSCONF)
				nxt.sysconf = data;
			else if (idx == `ZXP_XT_MEMCONF)
				nxt.memconf = data;
			else if (idx == `ZXP_XT_IM2VECT)
				nxt.im2vect = data;
			else if (idx == `ZXP_XT_FDDVIRT)
				nxt.fddvirt = data[3:0];
		end
		return nxt;
	endfunction

	function automatic zx_ports_pkg::data_t model_read(zx_ports_pkg::cfg_regs_t cur,
		zx_ports_pkg::addr_t addr, logic [4:0] keys, logic tape, logic dma);
		zx_ports_pkg::data_t rd;
		rd = 8'hFF;
		if ((addr[7:0] == `ZXP_PORTFE) || (addr[7:0] == `ZXP_PORTF6))
			rd = {1'b1, tape, 1'b0, keys};
		else if (addr[7:0] == `ZXP_PORTXT)
		begin
			if (addr[15:8] == `ZXP_XT_STATUS)
				rd = {dma, 7'b0000000};
			else if (addr[15:8] == 8'h12)
				rd = cur.rampage[2];
			else if (addr[15:8] == 8'h13)
				rd = cur.rampage[3];
		end
		else if ((addr[7:0] == `ZXP_PORTBE) && (addr[11:8] == 4'hA))
			rd = cur.p7ffd;
		else if ((addr[7:0] == `ZXP_PORTBE) && (addr[11:8] == 4'hB))
			rd = cur.peff7;
		return rd;
	endfunction

	function automatic logic model_oe(zx_ports_pkg::addr_t addr);
		logic hit;
		hit = (addr[7:0] == `ZXP_PORTFE) || (addr[7:0] == `ZXP_PORTF6) ||
			(addr[7:0] == `ZXP_PORTFD) || (addr[7:0] == `ZXP_PORTF7) ||
			(addr[7:0] == `ZXP_PORTXT) || (addr[7:0] == `ZXP_PORTBE);
		return hit && !((addr[7:0] == `ZXP_PORTFD) && addr[15]);  // AY answers elsewhere
	endfunction

	function automatic zx_ports_pkg::data_t model_peff7(zx_ports_pkg::data_t raw);
		return raw[2] ? (raw & `ZXP_EFF7_MASK) : raw;
	endfunction

	////////////////////////////////////////////////////////////
	// compare tasks
	task automatic stop_run(string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at cycle %0d", cycle_cnt);
	endtask

	task automatic check_data(string what, zx_ports_pkg::data_t exp, zx_ports_pkg::data_t act);
		if (act !== exp)
			stop_run($sformatf("** Error [%s] %s: expected %h, actual %h",
				test_name, what, exp, act));
	endtask

	task automatic check_page(string what, zx_ports_pkg::page_t exp, zx_ports_pkg::page_t act);
		if (act !== exp)
			stop_run($sformatf("** Error [%s] %s: expected %h, actual %h",
				test_name, what, exp, act));
	endtask

	task automatic check_flag(string what, logic exp, logic act);
		if (act !== exp)
			stop_run($sformatf("** Error [%s] %s: expected %b, actual %b",
				test_name, what, exp, act));
	endtask

	task automatic check_cfg(string what, zx_ports_pkg::cfg_regs_t exp,
		zx_ports_pkg::cfg_regs_t act);
		if (act !== exp)
			stop_run($sformatf("** Error [%s] %s: expected %h, actual %h",
				test_name, what, exp, act));
	endtask

	task automatic check_video(string what, zx_ports_pkg::video_wr_t exp,
		zx_ports_pkg::video_wr_t act);
		if (act !== exp)
			stop_run($sformatf("** Error [%s] %s: expected %h, actual %h",
				test_name, what, exp, act));
	endtask

	// register outputs against the model, away from the clock edge
	task automatic check_state(string what);
		int i;
		@(negedge zclk);
		check_cfg({what, " cfg"}, exp_cfg, cfg);
		check_data({what, " peff7"}, model_peff7(exp_cfg.peff7), peff7);
		check_flag({what, " rom"}, exp_cfg.memconf[0], p7ffd_rom);
		check_flag({what, " romrw"}, exp_cfg.memconf[1], romrw_en);
		for (i = 0; i < 4; i++)
			check_page($sformatf("%s xt_page %0d", what, i), exp_cfg.rampage[i],
				xt_page[i*8 +: 8]);
	endtask

	////////////////////////////////////////////////////////////
	// bus cycles, 4 clocks active then 2 idle
	task automatic bus_write(zx_ports_pkg::addr_t addr, zx_ports_pkg::data_t data);
		if ((addr[7:0] == `ZXP_PORTXT) && is_video_index(addr[15:8]))
			video_q.push_back('{valid: 1'b1, reg_idx: addr[15:8], data: data});
		@(posedge zclk);
		bus <= '{iorq_n: 1'b0, rd_n: 1'b1, wr_n: 1'b0, addr: addr, din: data};
		repeat (4) @(posedge zclk);
		bus <= BUS_IDLE;
		repeat (2) @(posedge zclk);
		exp_cfg = model_write(exp_cfg, addr, data);
	endtask

	task automatic read_check(string what, zx_ports_pkg::addr_t addr);
		@(posedge zclk);
		bus <= '{iorq_n: 1'b0, rd_n: 1'b0, wr_n: 1'b1, addr: addr, din: 8'hFF};
		@(negedge zclk);
		check_data(what, model_read(exp_cfg, addr, keys_in, tape_read, dma_act), dout);
		check_flag({what, " dataout"}, model_oe(addr), dataout);
		repeat (4) @(posedge zclk);
		bus <= BUS_IDLE;
		repeat (2) @(posedge zclk);
	endtask

	////////////////////////////////////////////////////////////
	// video writes seen on the output against the expected queue
	always @(negedge zclk)
	begin
		if (rst_n && video_wr.valid)
		begin
			if (video_q.size() == 0)
				stop_run("the DUT made a video register write that no bus cycle asked for");
			else
				check_video("video_wr", video_q.pop_front(), video_wr);
		end
	end

	always @(posedge zclk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
			stop_run("timeout: the tests did not finish within the cycle limit");
		else if (zx_ports_top_i.zx_ports_asserts_i.any_failed)
			stop_run("a bound assertion on the DUT failed");
	end

	initial
	begin
		zx_ports_pkg::data_t d;
		int                  i;

		rst_n     = 1'b0;
		bus       = BUS_IDLE;
		keys_in   = 5'h00;
		tape_read = 1'b0;
		dma_act   = 1'b0;
		exp_cfg   = reset_cfg();
		test_name = "reset";
		repeat (2) @(posedge zclk);
		rst_n <= 1'b1;

		check_state("after reset");
		read_check("AF 13", 16'h13AF);
		read_check("AF 12", 16'h12AF);

		test_name = "xt pages";
		for (i = 0; i < 4; i++)
		begin
			d = 8'($random(seed));
			bus_write({8'h10 + 8'(i), `ZXP_PORTXT}, d);
			check_state($sformatf("page %0d", i));
		end
		bus_write({`ZXP_XT_OVERRIDE, `ZXP_PORTXT}, 8'($random(seed)));
		check_state("override");
		bus_write({`ZXP_XT_FMADDR, `ZXP_PORTXT}, 8'($random(seed)));
		bus_write({`ZXP_XT_SYSCONF, `ZXP_PORTXT}, 8'($random(seed)));
		bus_write({`ZXP_XT_IM2VECT, `ZXP_PORTXT}, 8'($random(seed)));
		bus_write({`ZXP_XT_FDDVIRT, `ZXP_PORTXT}, 8'($random(seed)));
		bus_write({`ZXP_XT_MEMCONF, `ZXP_PORTXT}, 8'h02);
		check_state("config regs");
		read_check("AF 12", 16'h12AF);
		read_check("AF 13", 16'h13AF);

		test_name = "7ffd";
		bus_write(16'h7FFD, 8'($random(seed)) & 8'hDF);
		check_state("plain write");
		bus_write({`ZXP_XT_MEMCONF, `ZXP_PORTXT}, 8'h40);  // lock128
		bus_write(16'h7FFD, (8'($random(seed)) & 8'hDF) | 8'hC0);
		check_state("lock128 write");
		bus_write(16'h7FFD, (8'($random(seed)) & 8'h17) | 8'h20);  // sets the lock bit
		bus_write(16'h7FFD, 8'($random(seed)) & 8'hDF);
		check_state("locked write");
		read_check("BE A", 16'hFABE);

		test_name = "eff7";
		bus_write(16'hEFF7, 8'($random(seed)) & 8'hFB);
		check_state("unmasked");
		bus_write(16'hEFF7, 8'($random(seed)) | 8'h04);
		check_state("masked");
		bus_write(16'hFFF7, ~exp_cfg.peff7);  // a12 high, not eff7
		check_state("a12 high");
		read_check("BE B", 16'hFBBE);

		test_name = "video";
		bus_write({8'h03, `ZXP_PORTXT}, 8'($random(seed)));
		bus_write({`ZXP_XT_XBORDER, `ZXP_PORTXT}, 8'($random(seed)));
		bus_write({`ZXP_XT_TGPAGE, `ZXP_PORTXT}, 8'($random(seed)));
		bus_write({8'h23, `ZXP_PORTXT}, 8'($random(seed)));
		if (video_q.size() != 0)
			stop_run("a video register write never appeared on video_wr");
		check_state("after video writes");

		test_name = "input ports";
		for (i = 0; i < 4; i++)
		begin
			@(posedge zclk);
			keys_in   <= 5'($random(seed));
			tape_read <= 1'($random(seed));
			dma_act   <= 1'($random(seed));
			read_check("FE", {8'($random(seed)), `ZXP_PORTFE});
			read_check("F6", {8'($random(seed)), `ZXP_PORTF6});
			read_check("AF 00", {`ZXP_XT_STATUS, `ZXP_PORTXT});
			read_check("AY FFFD", 16'hFFFD);
		end

		if (!zx_ports_top_i.zx_ports_asserts_i.any_failed)
		begin
			$display("Simulation PASSED");
			$finish;
		end
		else
			stop_run("a bound assertion on the DUT failed");
	end

endmodule

// File: src.f
+incdir+common
common/zx_ports_pkg.sv
verilog/io_strobe_sync.sv
verilog/port_decoder.sv
xt_regs/xt_reg_bank.sv
verilog/port_read_mux.sv
verilog/zx_ports_top.sv
verif/zx_ports_asserts.sv
verif/tb_zx_ports.sv

// File: Makefile
TOP = tb_zx_ports

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f src.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns \
		-f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
